// File: conv_engine.f
design/conv_pkg.sv
design/tap_counter.sv
design/conv_ctrl.sv
design/mac_pipeline.sv
design/requant_unit.sv
design/conv_engine.sv
verif/conv_engine_tb.sv

// File: Bender.yml
package:
  name: conv_engine

sources:
  - design/conv_pkg.sv
  - design/tap_counter.sv
  - design/conv_ctrl.sv
  - design/mac_pipeline.sv
  - design/requant_unit.sv
  - design/conv_engine.sv
  - target: test
    files:
      - verif/conv_engine_tb.sv

// File: verif/conv_engine_tb.sv
// conv_engine_tb
// Drives windows into the convolution engine and checks each output pixel,
// its latency and the busy level against a behavioral reference.

`timescale 1ns/1ps

module conv_engine_tb;

  localparam int  N_TAPS    = 9;
  localparam time PERIOD    = 40;
  localparam int  LATENCY   = 5;  // edges from last accepted tap to out_valid
  localparam int  N_WINDOWS = 46;
  localparam int  TIMEOUT   = 40 * N_WINDOWS + 200;

  logic                 clk;
  logic                 rstn;
  logic                 start;
  conv_pkg::pixel_t     bias;
  logic                 tap_valid;
  conv_pkg::pixel_t     feat;
  conv_pkg::pixel_t     weight;
  logic                 out_valid;
  conv_pkg::out_pixel_t out_pixel;
  logic                 busy;

  logic [N_TAPS*8-1:0]  win_feat;
  logic [N_TAPS*8-1:0]  win_weight;
  conv_pkg::pixel_t     win_bias;
  logic [31:0]          lcg_state = 32'd98;

  conv_pkg::out_pixel_t exp_q [$];
  time                  last_q [$];  // time of the last tap's edge
  conv_pkg::out_pixel_t exp_pix;
  time                  t_last;
  int                   lat;
  logic                 busy_prev = 1'b0;
  int                   sent_cnt = 0;
  int                   pulse_cnt = 0;
  int                   mismatch_cnt = 0;
  int                   other_cnt = 0;
  int                   cycle_cnt = 0;

  conv_engine #(
    .N_TAPS (N_TAPS)
  ) u_dut (
    .clk       (clk),
    .rstn      (rstn),
    .start     (start),
    .bias      (bias),
    .tap_valid (tap_valid),
    .feat      (feat),
    .weight    (weight),
    .out_valid (out_valid),
    .out_pixel (out_pixel),
    .busy      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////////////////////////////////////////
  function automatic logic [7:0] lcg_byte();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  // sum of products plus bias at accumulator scale, then relu and clamp
  function automatic conv_pkg::out_pixel_t ref_pixel(input logic [N_TAPS*8-1:0] f,
                                                     input logic [N_TAPS*8-1:0] w,
                                                     input conv_pkg::pixel_t b);
    longint sum;
    longint quo;
    sum = longint'(b) * (longint'(1) << conv_pkg::FRAC_BITS);
    for (int i = 0; i < N_TAPS; i++) begin
      sum += longint'($signed(f[8*i +: 8])) * longint'($signed(w[8*i +: 8]));
    end
    if (sum < 0) return '0;
    quo = sum / (longint'(1) << conv_pkg::FRAC_BITS);
    if (quo > conv_pkg::OUT_MAX) return conv_pkg::out_pixel_t'(conv_pkg::OUT_MAX);
    return conv_pkg::out_pixel_t'(quo);
  endfunction

  task automatic fill_random();
    for (int i = 0; i < N_TAPS; i++) begin
      win_feat[8*i +: 8]   = lcg_byte();
      win_weight[8*i +: 8] = lcg_byte();
    end
    win_bias = lcg_byte();
  endtask

  task automatic fill_const(input conv_pkg::pixel_t f, input conv_pkg::pixel_t w,
                            input conv_pkg::pixel_t b);
    for (int i = 0; i < N_TAPS; i++) begin
      win_feat[8*i +: 8]   = f;
      win_weight[8*i +: 8] = w;
    end
    win_bias = b;
  endtask

  task automatic wait_idle();
    do @(negedge clk); while (busy);
    @(posedge clk);
  endtask

  // taps while no window is open must be dropped
  task automatic idle_taps(input int n);
    repeat (n) begin
      tap_valid <= 1'b1;
      feat      <= lcg_byte();
      weight    <= lcg_byte();
      @(posedge clk);
    end
    tap_valid <= 1'b0;
  endtask

  // called on a rising edge; chain leaves the next start on the edge busy falls
  task automatic send_window(input int gap_max, input bit stray, input bit chain);
    int gap;
    exp_q.push_back(ref_pixel(win_feat, win_weight, win_bias));
    sent_cnt++;
    start     <= 1'b1;
    bias      <= win_bias;
    tap_valid <= 1'b0;
    @(posedge clk);
    start <= 1'b0;
    for (int i = 0; i < N_TAPS; i++) begin
      gap = (gap_max > 0) ? int'(lcg_byte()) % (gap_max + 1) : 0;
      repeat (gap) begin
        tap_valid <= 1'b0;
        start     <= stray;      // window already open, so ignored
        bias      <= ~win_bias;  // a latched stray bias would change the pixel
        feat      <= lcg_byte();
        weight    <= lcg_byte();
        @(posedge clk);
      end
      start     <= 1'b0;
      tap_valid <= 1'b1;
      feat      <= win_feat[8*i +: 8];
      weight    <= win_weight[8*i +: 8];
      @(posedge clk);
    end
    tap_valid <= 1'b0;
    last_q.push_back($time);
    if (chain) begin
      repeat (LATENCY) @(posedge clk);
    end else begin
      if (stray) begin
        start <= 1'b1;  // lands in drain
        bias  <= ~win_bias;
        @(posedge clk);
        start <= 1'b0;
      end
      wait_idle();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // compare and timeout
  ////////////////////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (rstn && out_valid) begin
      pulse_cnt++;
      if (exp_q.size() == 0) begin
        $display("ERROR: out_valid pulsed with no window pending at %0t", $time);
        other_cnt++;
      end else begin
        exp_pix = exp_q.pop_front();
        t_last  = last_q.pop_front();
        lat     = int'(($time - t_last - PERIOD / 2) / PERIOD);
        if (out_pixel !== exp_pix) begin
          $display("MISMATCH out_pixel: got 0x%02h expected 0x%02h at %0t",
                   out_pixel, exp_pix, $time);
          mismatch_cnt++;
        end
        if (lat != LATENCY) begin
          $display("ERROR: out_valid came %0d cycles after the last tap, not %0d",
                   lat, LATENCY);
          other_cnt++;
        end
        if (busy !== 1'b0 || busy_prev !== 1'b1) begin
          $display("ERROR: busy did not fall on the edge of out_valid at %0t", $time);
          other_cnt++;
        end
      end
    end
    busy_prev = busy;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT) begin
      $display("ERROR: run did not complete within %0d cycles", TIMEOUT);
      $display("Finished with errors");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    rstn      = 1'b0;
    start     = 1'b0;
    bias      = '0;
    tap_valid = 1'b0;
    feat      = '0;
    weight    = '0;
    repeat (16) @(posedge clk);
    rstn <= 1'b1;
    @(posedge clk);

    for (int i = 0; i < 20; i++) begin
      fill_random();
      send_window(0, 1'b0, 1'b0);
    end

    fill_const(8'sd127, 8'sd127, 8'sd0);    // saturates high
    send_window(0, 1'b0, 1'b0);
    fill_const(-8'sd128, -8'sd128, 8'sd127);
    send_window(0, 1'b0, 1'b0);
    fill_const(8'sd127, -8'sd128, 8'sd0);   // large negative sum
    send_window(0, 1'b0, 1'b0);
    fill_const(-8'sd100, 8'sd90, -8'sd128);
    send_window(0, 1'b0, 1'b0);

    // same window back to back, then with gaps and stray starts
    for (int i = 0; i < 5; i++) begin
      fill_random();
      send_window(0, 1'b0, 1'b0);
      send_window(2, 1'b1, 1'b0);
    end

    // a full window's worth of idle taps would close a window if taken
    for (int i = 0; i < 4; i++) begin
      idle_taps(N_TAPS);
      fill_random();
      send_window(0, 1'b1, 1'b0);
    end

    for (int i = 0; i < 8; i++) begin
      fill_random();
      send_window(0, 1'b0, i < 7);
    end
    wait_idle();
    repeat (20) @(posedge clk);

    if (exp_q.size() != 0) begin
      $display("ERROR: %0d expected pixels never came out", exp_q.size());
      other_cnt++;
    end
    if (pulse_cnt != sent_cnt) begin
      $display("ERROR: %0d out_valid pulses for %0d windows", pulse_cnt, sent_cnt);
      other_cnt++;
    end
    $display("errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: design/conv_engine.sv
// conv_engine
// Computes one output pixel per 3x3 window: controller, tap counter,
// pipelined MAC and requantization.

`timescale 1ns/1ps

module conv_engine #(
  parameter int N_TAPS = 9
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 start,
  input  conv_pkg::pixel_t     bias,
  input  logic                 tap_valid,
  input  conv_pkg::pixel_t     feat,
  input  conv_pkg::pixel_t     weight,
  output logic                 out_valid,
  output conv_pkg::out_pixel_t out_pixel,
  output logic                 busy
);

  logic           win_open;
  logic           tap_accept;
  logic           tap_first;
  logic           tap_last;
  logic           acc_done;
  conv_pkg::acc_t acc;

  ////////////////////////////////////////////////////////////////////////////
  // control
  ////////////////////////////////////////////////////////////////////////////
  conv_ctrl u_ctrl (
    .clk        (clk),
    .rstn       (rstn),
    .start      (start),
    .tap_valid  (tap_valid),
    .tap_last   (tap_last),
    .acc_done   (acc_done),
    .win_open   (win_open),
    .tap_accept (tap_accept),
    .busy       (busy)
  );

  tap_counter #(
    .N_TAPS (N_TAPS)
  ) u_tap_counter (
    .clk        (clk),
    .rstn       (rstn),
    .clear      (win_open),
    .tap_accept (tap_accept),
    .tap_first  (tap_first),
    .tap_last   (tap_last)
  );

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////
  mac_pipeline u_mac (
    .clk        (clk),
    .rstn       (rstn),
    .tap_accept (tap_accept),
    .tap_first  (tap_first),
    .tap_last   (tap_last),
    .feat       (feat),
    .weight     (weight),
    .acc_done   (acc_done),
    .acc        (acc)
  );

  requant_unit u_requant (
    .clk       (clk),
    .rstn      (rstn),
    .win_open  (win_open),
    .bias      (bias),
    .acc_done  (acc_done),
    .acc       (acc),
    .out_valid (out_valid),
    .out_pixel (out_pixel)
  );

endmodule

// File: design/requant_unit.sv
// requant_unit
// Adds the window bias at accumulator scale, then rectifies and saturates
// the sum to a 7-bit positive pixel.

`timescale 1ns/1ps

module requant_unit (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 win_open,
  input  conv_pkg::pixel_t     bias,
  input  logic                 acc_done,
  input  conv_pkg::acc_t       acc,
  output logic                 out_valid,
  output conv_pkg::out_pixel_t out_pixel
);

  conv_pkg::pixel_t bias_q;
  conv_pkg::acc_t   sum;
  conv_pkg::acc_t   sum_int; // integer part of the biased sum

  always_ff @(posedge clk) begin
    if (win_open) bias_q <= bias; // held for the whole window
  end

  assign sum     = acc + (conv_pkg::acc_t'(bias_q) <<< conv_pkg::FRAC_BITS);
  assign sum_int = sum >>> conv_pkg::FRAC_BITS;

  always_ff @(posedge clk) begin
    if (acc_done) begin
      if (sum < 0)                         out_pixel <= '0; // relu
      else if (sum_int > conv_pkg::OUT_MAX) out_pixel <= conv_pkg::out_pixel_t'(conv_pkg::OUT_MAX);
      else                                 out_pixel <= conv_pkg::out_pixel_t'(sum_int);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= acc_done;
    end
  end

endmodule

// File: design/mac_pipeline.sv
// mac_pipeline
// Four-stage signed 8x8 multiplier (magnitude, partial products, adder
// tree, sign restore) feeding a tagged accumulator. Several taps can be
// in flight at once.

`timescale 1ns/1ps

module mac_pipeline (
  input  logic             clk,
  input  logic             rstn,
  input  logic             tap_accept,
  input  logic             tap_first,
  input  logic             tap_last,
  input  conv_pkg::pixel_t feat,
  input  conv_pkg::pixel_t weight,
  output logic             acc_done,
  output conv_pkg::acc_t   acc
);

  conv_pkg::mag_t feat_mag;
  conv_pkg::mag_t weight_mag;

  // stage registers
  conv_pkg::mag_t pp_q [8];   // partial products of stage 1
  logic [9:0]     s2_q [4];   // pairwise sums, shift 1
  logic [11:0]    s3_q [2];   // pairwise sums, shift 2
  logic [15:0]    mag16;      // final unsigned sum, shift 4
  conv_pkg::prod_t prod_q;    // signed product of stage 4
  conv_pkg::acc_t  acc_q;

  logic [3:1] sign_q;
  logic [4:1] valid_q;
  logic [4:1] first_q;
  logic [4:1] last_q;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1: magnitudes and partial products
  ////////////////////////////////////////////////////////////////////////////
  assign feat_mag   = feat[7]   ? conv_pkg::mag_t'(-feat)   : conv_pkg::mag_t'(feat);
  assign weight_mag = weight[7] ? conv_pkg::mag_t'(-weight) : conv_pkg::mag_t'(weight);

  always_ff @(posedge clk) begin
    for (int i = 0; i < 8; i++) begin
      pp_q[i] <= weight_mag[i] ? feat_mag : '0;
    end
    sign_q[1] <= feat[7] ^ weight[7];
  end

  ////////////////////////////////////////////////////////////////////////////
  // stages 2 and 3: adder tree
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    for (int j = 0; j < 4; j++) begin
      s2_q[j] <= {2'b00, pp_q[2*j]} + {1'b0, pp_q[2*j+1], 1'b0};
    end
    for (int k = 0; k < 2; k++) begin
      s3_q[k] <= {2'b00, s2_q[2*k]} + {s2_q[2*k+1], 2'b00};
    end
    sign_q[2] <= sign_q[1];
    sign_q[3] <= sign_q[2];
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 4: last add and sign restore
  ////////////////////////////////////////////////////////////////////////////
  assign mag16 = {4'b0000, s3_q[0]} + {s3_q[1], 4'b0000};

  always_ff @(posedge clk) begin
    prod_q <= sign_q[3] ? conv_pkg::prod_t'(-mag16) : conv_pkg::prod_t'(mag16);
  end

  // tags travel beside the data, gated by valid at the entry
  always_ff @(posedge clk) begin
    if (!rstn) begin
      valid_q <= '0;
      first_q <= '0;
      last_q  <= '0;
    end else begin
      valid_q <= {valid_q[3:1], tap_accept};
      first_q <= {first_q[3:1], tap_accept & tap_first};
      last_q  <= {last_q[3:1],  tap_accept & tap_last};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // accumulate
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (valid_q[4]) begin
      if (first_q[4]) acc_q <= conv_pkg::acc_t'(prod_q);         // first tap loads
      else            acc_q <= acc_q + conv_pkg::acc_t'(prod_q);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      acc_done <= 1'b0;
    end else begin
      acc_done <= valid_q[4] & last_q[4]; // window sum complete
    end
  end

  assign acc = acc_q;

  // tags that reach the accumulator always belong to a real tap
  a_tag_valid : assert property (@(posedge clk) disable iff (!rstn)
    (first_q[4] || last_q[4]) |-> valid_q[4])
    else $error("first/last tag without valid");

endmodule

// File: design/conv_ctrl.sv
// conv_ctrl
// Window controller. Opens a window on start, gates taps while collecting
// and waits for the accumulated result before going idle again.

`timescale 1ns/1ps

module conv_ctrl (
  input  logic clk,
  input  logic rstn,
  input  logic start,
  input  logic tap_valid,
  input  logic tap_last,
  input  logic acc_done,
  output logic win_open,
  output logic tap_accept,
  output logic busy
);

  conv_pkg::ctrl_state_t state_q;
  conv_pkg::ctrl_state_t state_d;

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    state_d = state_q;
    case (state_q)
      conv_pkg::ST_IDLE: begin
        if (start) state_d = conv_pkg::ST_COLLECT;
      end
      conv_pkg::ST_COLLECT: begin
        // window closes on the last accepted tap
        if (tap_accept && tap_last) state_d = conv_pkg::ST_DRAIN;
      end
      conv_pkg::ST_DRAIN: begin
        if (acc_done) state_d = conv_pkg::ST_IDLE; // lines up with out_valid
      end
      default: state_d = conv_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q <= conv_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////////////////////
  assign win_open   = start && (state_q == conv_pkg::ST_IDLE);
  assign tap_accept = tap_valid && (state_q == conv_pkg::ST_COLLECT);
  assign busy       = (state_q != conv_pkg::ST_IDLE);

  // after any accepted tap the window is still open or draining
  a_tap_in_window : assert property (@(posedge clk) disable iff (!rstn)
    tap_accept |=> state_q inside {conv_pkg::ST_COLLECT, conv_pkg::ST_DRAIN})
    else $error("tap accepted outside a window");

  // the pipeline only reports a sum for a closed window
  a_done_in_drain : assert property (@(posedge clk) disable iff (!rstn)
    acc_done |-> state_q == conv_pkg::ST_DRAIN)
    else $error("acc_done outside ST_DRAIN");

endmodule

// File: design/tap_counter.sv
// tap_counter
// Counts the accepted taps of one window and flags the first and the
// last tap combinationally from the current index.

`timescale 1ns/1ps

module tap_counter #(
  parameter int N_TAPS = 9
) (
  input  logic clk,
  input  logic rstn,
  input  logic clear,
  input  logic tap_accept,
  output logic tap_first,
  output logic tap_last
);

  localparam int IDX_W = (N_TAPS > 1) ? $clog2(N_TAPS) : 1;
  localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(N_TAPS - 1);

  logic [IDX_W-1:0] idx_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      idx_q <= '0;
    end else if (clear) begin
      idx_q <= '0; // new window
    end else if (tap_accept) begin
      if (idx_q == IDX_LAST) idx_q <= '0; // wrap after the last tap
      else                   idx_q <= idx_q + 1'b1;
    end
  end

  assign tap_first = (idx_q == '0);
  assign tap_last  = (idx_q == IDX_LAST);

  // the index must stay inside the window
  a_idx_range : assert property (@(posedge clk) disable iff (!rstn)
    idx_q <= IDX_LAST)
    else $error("tap index %0d beyond last tap", idx_q);

endmodule

// File: design/conv_pkg.sv
// conv_pkg
// Shared widths, fixed-point constants and controller states for the
// 3x3 convolution engine.

package conv_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // data widths
  ////////////////////////////////////////////////////////////////////////////
  typedef logic signed [7:0]  pixel_t;     // feature, weight or bias
  typedef logic        [7:0]  mag_t;       // operand magnitude, 0..128
  typedef logic signed [15:0] prod_t;      // one signed product
  typedef logic signed [27:0] acc_t;       // accumulated window sum
  typedef logic        [7:0]  out_pixel_t; // rectified pixel, 0..127

  ////////////////////////////////////////////////////////////////////////////
  // fixed point
  ////////////////////////////////////////////////////////////////////////////
  // accumulator carries 6 more fraction bits than the bias
  localparam int FRAC_BITS = 6;
  localparam int OUT_MAX   = 127; // saturation ceiling

  // controller states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_COLLECT,
    ST_DRAIN
  } ctrl_state_t;

endpackage
